//--- rtl/axis_in_config.svh
//******************************
// Widths, FIFO depth and CSR map
// of the stream input block
//******************************
`ifndef AXIS_IN_CONFIG_SVH
`define AXIS_IN_CONFIG_SVH

// Stream and word sizes
`define AXIS_IN_TDATA_W 8
`define AXIS_IN_DATA_W 32
`define AXIS_IN_LANES 4

// FIFO holds 2**ADDR_W words, level needs one extra bit
`define AXIS_IN_FIFO_ADDR_W 4
`define AXIS_IN_LEVEL_W (`AXIS_IN_FIFO_ADDR_W + 1)

// Received beat counter
`define AXIS_IN_CNT_W 16

// Register map
`define AXIS_IN_CSR_ADDR_W 4
`define AXIS_IN_ADDR_SOFT_RESET 4'd0
`define AXIS_IN_ADDR_ENABLE 4'd1
`define AXIS_IN_ADDR_MODE 4'd2
`define AXIS_IN_ADDR_THRESHOLD 4'd3
`define AXIS_IN_ADDR_DATA 4'd4
`define AXIS_IN_ADDR_LEVEL 4'd5
`define AXIS_IN_ADDR_STATUS 4'd6
`define AXIS_IN_ADDR_NWORDS 4'd7

`endif

//--- rtl/axis_in_pkg.sv
//******************************
// Shared FIFO word type
//******************************
`default_nettype none

`include "axis_in_config.svh"

package axis_in_pkg;

   // One FIFO word, seen either as beat lanes or as a flat value
   // Lane 0 sits in the low byte
   typedef union packed {
      logic [`AXIS_IN_LANES-1:0][`AXIS_IN_TDATA_W-1:0] lanes;
      logic [`AXIS_IN_DATA_W-1:0]                      word;
   } fifo_word_u;

endpackage

`default_nettype wire

//--- rtl/axis_in_packer.sv
//******************************
// Byte stream to word packer with
// tlast padding and beat counter
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "axis_in_config.svh"

module axis_in_packer
   import axis_in_pkg::*;
(
   input  wire                       clk_i,
   input  wire                       rst_i,
   input  wire                       sw_rst_i,
   input  wire                       enable_i,
   input  wire                       mode_i,
   input  wire                       axis_tvalid_i,
   input  wire [`AXIS_IN_TDATA_W-1:0] axis_tdata_i,
   input  wire                       axis_tlast_i,
   output logic                      axis_tready_o,
   input  wire                       fifo_full_i,
   output logic                      fifo_wen_o,
   output fifo_word_u                fifo_wdata_o,
   output logic [`AXIS_IN_CNT_W-1:0] nwords_o,
   output logic                      tlast_detected_o
);

   localparam int LANE_W = $clog2(`AXIS_IN_LANES);

   logic [LANE_W-1:0]         lane_idx_q;
   logic                      tlast_q;
   logic [`AXIS_IN_CNT_W-1:0] cnt_q;
   logic                      accept;
   logic                      last_lane;
   fifo_word_u                partial_q;
   fifo_word_u                merged;

   // CPU mode stops taking beats once the end of stream was seen
   assign axis_tready_o = enable_i & ~fifo_full_i & ~(~mode_i & tlast_q);
   assign accept        = axis_tvalid_i & axis_tready_o;
   assign last_lane     = (lane_idx_q == LANE_W'(`AXIS_IN_LANES - 1));

   // Current beat merged into stored lanes, upper lanes cleared
   always_comb begin
      merged = partial_q;
      merged.lanes[lane_idx_q] = axis_tdata_i;
      for (int i = 0; i < `AXIS_IN_LANES; i++) begin
         if (i > int'(lane_idx_q)) begin
            merged.lanes[i] = '0;
         end
      end
   end

   assign fifo_wen_o       = accept & (last_lane | axis_tlast_i);
   assign fifo_wdata_o     = merged;
   assign nwords_o         = cnt_q;
   assign tlast_detected_o = tlast_q;

   always_ff @(posedge clk_i) begin
      if (rst_i || sw_rst_i) begin
         lane_idx_q <= '0;
         tlast_q    <= 1'b0;
         cnt_q      <= '0;
      end else if (accept) begin
         if (fifo_wen_o) begin
            lane_idx_q <= '0;
         end else begin
            lane_idx_q <= lane_idx_q + 1'b1;
         end
         if (axis_tlast_i) begin
            tlast_q <= 1'b1;
         end
         // The tlast beat itself still counts
         if (!tlast_q) begin
            cnt_q <= cnt_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         partial_q <= merged;
      end
   end

   // No beat is taken while the FIFO reports full
   a_hold_when_full : assert property (
      @(posedge clk_i) disable iff (rst_i)
      fifo_full_i && !sw_rst_i |=> $stable(lane_idx_q) && $stable(cnt_q));

   // Disabled block takes no beats
   a_idle_when_disabled : assert property (
      @(posedge clk_i) disable iff (rst_i)
      !enable_i && !sw_rst_i |=>
         $stable(lane_idx_q) && $stable(cnt_q) && $stable(tlast_q));

endmodule

`default_nettype wire

//--- rtl/axis_in_fifo.sv
//******************************
// Show-ahead word FIFO with level
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "axis_in_config.svh"

module axis_in_fifo
   import axis_in_pkg::*;
(
   input  wire                         clk_i,
   input  wire                         rst_i,
   input  wire                         sw_rst_i,
   input  wire                         wen_i,
   input  fifo_word_u                  wdata_i,
   input  wire                         ren_i,
   output fifo_word_u                  rdata_o,
   output logic                        empty_o,
   output logic                        full_o,
   output logic [`AXIS_IN_LEVEL_W-1:0] level_o
);

   localparam int DEPTH = 1 << `AXIS_IN_FIFO_ADDR_W;

   fifo_word_u                      mem [DEPTH];
   logic [`AXIS_IN_FIFO_ADDR_W-1:0] wptr_q;
   logic [`AXIS_IN_FIFO_ADDR_W-1:0] rptr_q;
   logic [`AXIS_IN_LEVEL_W-1:0]     level_q;
   logic                            wr_en;
   logic                            rd_en;

   assign empty_o = (level_q == '0);
   assign full_o  = (level_q == `AXIS_IN_LEVEL_W'(DEPTH));
   assign level_o = level_q;
   assign wr_en   = wen_i & ~full_o;
   assign rd_en   = ren_i & ~empty_o;

   // Head word is always visible
   assign rdata_o = mem[rptr_q];

   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem[wptr_q] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || sw_rst_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else begin
         if (wr_en) wptr_q <= wptr_q + 1'b1;
         if (rd_en) rptr_q <= rptr_q + 1'b1;
         case ({wr_en, rd_en})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   a_no_overflow : assert property (
      @(posedge clk_i) disable iff (rst_i) wen_i |-> !full_o);

   a_no_underflow : assert property (
      @(posedge clk_i) disable iff (rst_i) ren_i |-> !empty_o);

endmodule

`default_nettype wire

//--- rtl/axis_in_csrs.sv
//******************************
// Control registers, FIFO drain
// and threshold interrupt
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "axis_in_config.svh"

module axis_in_csrs
   import axis_in_pkg::*;
(
   input  wire                            clk_i,
   input  wire                            rst_i,
   input  wire                            csr_valid_i,
   input  wire                            csr_wen_i,
   input  wire [`AXIS_IN_CSR_ADDR_W-1:0]  csr_addr_i,
   input  wire [`AXIS_IN_DATA_W-1:0]      csr_wdata_i,
   output logic [`AXIS_IN_DATA_W-1:0]     csr_rdata_o,
   output logic                           csr_rvalid_o,
   output logic                           sw_rst_o,
   output logic                           enable_o,
   output logic                           mode_o,
   input  fifo_word_u                     fifo_rdata_i,
   input  wire                            fifo_empty_i,
   input  wire                            fifo_full_i,
   input  wire [`AXIS_IN_LEVEL_W-1:0]     fifo_level_i,
   output logic                           fifo_ren_o,
   input  wire [`AXIS_IN_CNT_W-1:0]       nwords_i,
   input  wire                            tlast_detected_i,
   output logic                           sys_tvalid_o,
   output logic [`AXIS_IN_DATA_W-1:0]     sys_tdata_o,
   input  wire                            sys_tready_i,
   output logic                           interrupt_o
);

   logic                         sw_rst_q;
   logic                         enable_q;
   logic                         mode_q;
   logic [`AXIS_IN_LEVEL_W-1:0]  thresh_q;
   logic                         rvalid_q;
   logic [`AXIS_IN_DATA_W-1:0]   rdata_q;
   logic [`AXIS_IN_DATA_W-1:0]   rdata_d;
   logic                         csr_wr;
   logic                         csr_rd;
   logic                         cpu_data_avail;
   logic                         cpu_pop;

   assign csr_wr         = csr_valid_i & csr_wen_i;
   assign csr_rd         = csr_valid_i & ~csr_wen_i;
   assign cpu_data_avail = ~mode_q & ~fifo_empty_i;
   assign cpu_pop        = csr_rd & (csr_addr_i == `AXIS_IN_ADDR_DATA) & cpu_data_avail;

   // System stream owns the FIFO head in mode 1
   assign sys_tvalid_o = mode_q & ~fifo_empty_i;
   assign sys_tdata_o  = fifo_rdata_i.word;
   assign fifo_ren_o   = mode_q ? (sys_tvalid_o & sys_tready_i) : cpu_pop;

   assign interrupt_o  = (fifo_level_i >= thresh_q);

   assign sw_rst_o     = sw_rst_q;
   assign enable_o     = enable_q;
   assign mode_o       = mode_q;
   assign csr_rdata_o  = rdata_q;
   assign csr_rvalid_o = rvalid_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sw_rst_q <= 1'b0;
         enable_q <= 1'b0;
         mode_q   <= 1'b0;
         thresh_q <= `AXIS_IN_LEVEL_W'(1);
      end else if (csr_wr) begin
         case (csr_addr_i)
            `AXIS_IN_ADDR_SOFT_RESET: sw_rst_q <= csr_wdata_i[0];
            `AXIS_IN_ADDR_ENABLE:     enable_q <= csr_wdata_i[0];
            `AXIS_IN_ADDR_MODE:       mode_q   <= csr_wdata_i[0];
            `AXIS_IN_ADDR_THRESHOLD:  thresh_q <= csr_wdata_i[`AXIS_IN_LEVEL_W-1:0];
            default: ;
         endcase
      end
   end

   // Read decode, returned one cycle after the access
   always_comb begin
      rdata_d = '0;
      case (csr_addr_i)
         `AXIS_IN_ADDR_SOFT_RESET: rdata_d[0] = sw_rst_q;
         `AXIS_IN_ADDR_ENABLE:     rdata_d[0] = enable_q;
         `AXIS_IN_ADDR_MODE:       rdata_d[0] = mode_q;
         `AXIS_IN_ADDR_THRESHOLD:  rdata_d[`AXIS_IN_LEVEL_W-1:0] = thresh_q;
         `AXIS_IN_ADDR_DATA: begin
            if (cpu_data_avail) rdata_d = fifo_rdata_i.word;
         end
         `AXIS_IN_ADDR_LEVEL:      rdata_d[`AXIS_IN_LEVEL_W-1:0] = fifo_level_i;
         `AXIS_IN_ADDR_STATUS:     rdata_d[2:0] = {tlast_detected_i, fifo_full_i, fifo_empty_i};
         `AXIS_IN_ADDR_NWORDS:     rdata_d[`AXIS_IN_CNT_W-1:0] = nwords_i;
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= csr_rd;
      end
   end

   always_ff @(posedge clk_i) begin
      if (csr_rd) begin
         rdata_q <= rdata_d;
      end
   end

endmodule

`default_nettype wire

//--- rtl/axis_in_top.sv
//******************************
// Stream input peripheral top
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "axis_in_config.svh"

module axis_in_top
   import axis_in_pkg::*;
(
   input  wire                           clk_i,
   input  wire                           rst_i,
   // Byte stream in
   input  wire                           axis_tvalid_i,
   input  wire [`AXIS_IN_TDATA_W-1:0]    axis_tdata_i,
   input  wire                           axis_tlast_i,
   output logic                          axis_tready_o,
   // Word stream out
   output logic                          sys_tvalid_o,
   output logic [`AXIS_IN_DATA_W-1:0]    sys_tdata_o,
   input  wire                           sys_tready_i,
   // Register bus
   input  wire                           csr_valid_i,
   input  wire                           csr_wen_i,
   input  wire [`AXIS_IN_CSR_ADDR_W-1:0] csr_addr_i,
   input  wire [`AXIS_IN_DATA_W-1:0]     csr_wdata_i,
   output logic [`AXIS_IN_DATA_W-1:0]    csr_rdata_o,
   output logic                          csr_rvalid_o,
   output logic                          interrupt_o
);

   logic                        sw_rst;
   logic                        enable;
   logic                        mode;
   logic                        fifo_wen;
   fifo_word_u                  fifo_wdata;
   logic                        fifo_ren;
   fifo_word_u                  fifo_rdata;
   logic                        fifo_empty;
   logic                        fifo_full;
   logic [`AXIS_IN_LEVEL_W-1:0] fifo_level;
   logic [`AXIS_IN_CNT_W-1:0]   nwords;
   logic                        tlast_detected;

   axis_in_packer u_packer (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .sw_rst_i        (sw_rst),
      .enable_i        (enable),
      .mode_i          (mode),
      .axis_tvalid_i   (axis_tvalid_i),
      .axis_tdata_i    (axis_tdata_i),
      .axis_tlast_i    (axis_tlast_i),
      .axis_tready_o   (axis_tready_o),
      .fifo_full_i     (fifo_full),
      .fifo_wen_o      (fifo_wen),
      .fifo_wdata_o    (fifo_wdata),
      .nwords_o        (nwords),
      .tlast_detected_o(tlast_detected)
   );

   axis_in_fifo u_fifo (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .sw_rst_i(sw_rst),
      .wen_i   (fifo_wen),
      .wdata_i (fifo_wdata),
      .ren_i   (fifo_ren),
      .rdata_o (fifo_rdata),
      .empty_o (fifo_empty),
      .full_o  (fifo_full),
      .level_o (fifo_level)
   );

   axis_in_csrs u_csrs (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .csr_valid_i     (csr_valid_i),
      .csr_wen_i       (csr_wen_i),
      .csr_addr_i      (csr_addr_i),
      .csr_wdata_i     (csr_wdata_i),
      .csr_rdata_o     (csr_rdata_o),
      .csr_rvalid_o    (csr_rvalid_o),
      .sw_rst_o        (sw_rst),
      .enable_o        (enable),
      .mode_o          (mode),
      .fifo_rdata_i    (fifo_rdata),
      .fifo_empty_i    (fifo_empty),
      .fifo_full_i     (fifo_full),
      .fifo_level_i    (fifo_level),
      .fifo_ren_o      (fifo_ren),
      .nwords_i        (nwords),
      .tlast_detected_i(tlast_detected),
      .sys_tvalid_o    (sys_tvalid_o),
      .sys_tdata_o     (sys_tdata_o),
      .sys_tready_i    (sys_tready_i),
      .interrupt_o     (interrupt_o)
   );

endmodule

`default_nettype wire

//--- dv/axis_in_tb.sv
//******************************
// Directed testbench for the
// stream input peripheral
//******************************
`timescale 1ns/1ps
`default_nettype none

`include "axis_in_config.svh"

module axis_in_tb;

   localparam int NUM_TESTS   = 6;
   // Accepted beats plus the held beats of the refusal checks
   localparam int TOTAL_BEATS = 8 + 6 + 65 + 12 + 44 + 2;
   localparam int LIMIT_CYC   = 400 * NUM_TESTS + 4 * TOTAL_BEATS;

   logic        clk;
   logic        rst_i;
   logic        axis_tvalid_i;
   logic [7:0]  axis_tdata_i;
   logic        axis_tlast_i;
   logic        axis_tready_o;
   logic        sys_tvalid_o;
   logic [31:0] sys_tdata_o;
   logic        sys_tready_i;
   logic        csr_valid_i;
   logic        csr_wen_i;
   logic [3:0]  csr_addr_i;
   logic [31:0] csr_wdata_i;
   logic [31:0] csr_rdata_o;
   logic        csr_rvalid_o;
   logic        interrupt_o;

   int          errors;
   string       test_name;
   // Reference packer state and expected words
   logic [31:0] model_acc;
   int          model_lane;
   logic [31:0] exp_q[$];

   axis_in_top u_axis_in_top (
      .clk_i        (clk),
      .rst_i        (rst_i),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tdata_i (axis_tdata_i),
      .axis_tlast_i (axis_tlast_i),
      .axis_tready_o(axis_tready_o),
      .sys_tvalid_o (sys_tvalid_o),
      .sys_tdata_o  (sys_tdata_o),
      .sys_tready_i (sys_tready_i),
      .csr_valid_i  (csr_valid_i),
      .csr_wen_i    (csr_wen_i),
      .csr_addr_i   (csr_addr_i),
      .csr_wdata_i  (csr_wdata_i),
      .csr_rdata_o  (csr_rdata_o),
      .csr_rvalid_o (csr_rvalid_o),
      .interrupt_o  (interrupt_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      repeat (LIMIT_CYC) @(posedge clk);
      $display("Watchdog expired after %0d cycles, tests did not finish", LIMIT_CYC);
      $display("Errors counted before the timeout: %0d", errors);
      $display("Testbench failed");
      $finish;
   end

   task automatic check_value(input string what, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp) else begin
         $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
         errors++;
      end
   endtask

   // Lane rule with zero fill above a tlast beat
   task automatic model_beat(input logic [7:0] data, input logic last);
      model_acc[model_lane*`AXIS_IN_TDATA_W +: `AXIS_IN_TDATA_W] = data;
      if (model_lane == `AXIS_IN_LANES - 1 || last) begin
         exp_q.push_back(model_acc);
         model_acc  = '0;
         model_lane = 0;
      end else begin
         model_lane++;
      end
   endtask

   task automatic csr_write(input logic [3:0] addr, input logic [31:0] data);
      csr_valid_i = 1'b1;
      csr_wen_i   = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      @(negedge clk);
      csr_valid_i = 1'b0;
      csr_wen_i   = 1'b0;
   endtask

   task automatic csr_read(input logic [3:0] addr, output logic [31:0] data);
      csr_valid_i = 1'b1;
      csr_wen_i   = 1'b0;
      csr_addr_i  = addr;
      @(negedge clk);
      csr_valid_i = 1'b0;
      assert (csr_rvalid_o === 1'b1) else begin
         $display("Read of register %0d in %s gave no read valid one cycle later",
                  addr, test_name);
         errors++;
      end
      data = csr_rdata_o;
   endtask

   task automatic read_expect(input string what, input logic [3:0] addr,
                              input logic [31:0] exp);
      logic [31:0] val;
      csr_read(addr, val);
      check_value(what, exp, val);
   endtask

   task automatic drain_word(output logic [31:0] got);
      logic [31:0] exp_word;
      exp_word = exp_q.pop_front();
      csr_read(`AXIS_IN_ADDR_DATA, got);
      check_value("DATA word", exp_word, got);
   endtask

   task automatic send_beat(input logic [7:0] data, input logic last);
      axis_tvalid_i = 1'b1;
      axis_tdata_i  = data;
      axis_tlast_i  = last;
      while (!axis_tready_o) @(negedge clk);
      // Ready is settled, the beat goes in at the next rising edge
      model_beat(data, last);
      @(negedge clk);
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
   endtask

   task automatic hold_refused_beat(input logic [7:0] data, input int cycles);
      axis_tvalid_i = 1'b1;
      axis_tdata_i  = data;
      axis_tlast_i  = 1'b0;
      repeat (cycles) begin
         check_value("held beat tready", 32'd0, 32'(axis_tready_o));
         @(negedge clk);
      end
      axis_tvalid_i = 1'b0;
   endtask

   task automatic collect_sys_words(input int count);
      int          got;
      int          waited;
      logic [31:0] exp_word;
      got    = 0;
      waited = 0;
      while (got < count && waited < 2000) begin
         sys_tready_i = 1'($urandom);
         if (sys_tvalid_o && sys_tready_i) begin
            exp_word = exp_q.pop_front();
            check_value("sys word", exp_word, sys_tdata_o);
            got++;
         end
         @(negedge clk);
         waited++;
      end
      sys_tready_i = 1'b0;
      assert (got == count) else begin
         $display("System stream in %s delivered only %0d of %0d words",
                  test_name, got, count);
         errors++;
      end
   endtask

   task automatic restart_block(input logic en, input logic md);
      exp_q.delete();
      model_acc    = '0;
      model_lane   = 0;
      sys_tready_i = 1'b0;
      csr_write(`AXIS_IN_ADDR_SOFT_RESET, 32'd1);
      csr_write(`AXIS_IN_ADDR_SOFT_RESET, 32'd0);
      csr_write(`AXIS_IN_ADDR_MODE, {31'd0, md});
      csr_write(`AXIS_IN_ADDR_ENABLE, {31'd0, en});
   endtask

   task automatic check_after_reset();
      test_name = "after_reset";
      check_value("tready", 32'd0, 32'(axis_tready_o));
      check_value("sys tvalid", 32'd0, 32'(sys_tvalid_o));
      check_value("rvalid", 32'd0, 32'(csr_rvalid_o));
      check_value("interrupt", 32'd0, 32'(interrupt_o));
      read_expect("THRESHOLD", `AXIS_IN_ADDR_THRESHOLD, 32'd1);
      read_expect("LEVEL", `AXIS_IN_ADDR_LEVEL, 32'd0);
   endtask

   task automatic cpu_mode_packing();
      logic [31:0] w;
      test_name = "cpu_mode_packing";
      restart_block(1'b1, 1'b0);
      repeat (8) send_beat(8'($urandom), 1'b0);
      repeat (2) drain_word(w);
      read_expect("NWORDS", `AXIS_IN_ADDR_NWORDS, 32'd8);
      read_expect("LEVEL", `AXIS_IN_ADDR_LEVEL, 32'd0);
   endtask

   task automatic tlast_padding_and_stop();
      logic [31:0] w;
      test_name = "tlast_padding_and_stop";
      restart_block(1'b1, 1'b0);
      for (int i = 0; i < 6; i++) begin
         send_beat(8'($urandom), i == 5);
      end
      drain_word(w);
      drain_word(w);
      check_value("padded lanes", 32'd0, {16'd0, w[31:16]});
      // Empty with the end of stream flag set
      read_expect("STATUS", `AXIS_IN_ADDR_STATUS, 32'h5);
      hold_refused_beat(8'hA5, 8);
      restart_block(1'b1, 1'b0);
      read_expect("STATUS after soft reset", `AXIS_IN_ADDR_STATUS, 32'h1);
      read_expect("NWORDS after soft reset", `AXIS_IN_ADDR_NWORDS, 32'd0);
      check_value("tready after soft reset", 32'd1, 32'(axis_tready_o));
   endtask

   task automatic full_fifo_backpressure();
      logic [31:0] w;
      test_name = "full_fifo_backpressure";
      restart_block(1'b1, 1'b0);
      repeat (64) send_beat(8'($urandom), 1'b0);
      read_expect("LEVEL", `AXIS_IN_ADDR_LEVEL, 32'd16);
      read_expect("STATUS", `AXIS_IN_ADDR_STATUS, 32'h2);
      check_value("tready when full", 32'd0, 32'(axis_tready_o));
      // The 65th beat waits until draining frees a slot
      fork
         send_beat(8'h5A, 1'b0);
         repeat (16) drain_word(w);
      join
      read_expect("NWORDS", `AXIS_IN_ADDR_NWORDS, 32'd65);
      read_expect("LEVEL after drain", `AXIS_IN_ADDR_LEVEL, 32'd0);
   endtask

   task automatic level_interrupt();
      logic [31:0] w;
      test_name = "level_interrupt";
      restart_block(1'b1, 1'b0);
      csr_write(`AXIS_IN_ADDR_THRESHOLD, 32'd3);
      repeat (8) send_beat(8'($urandom), 1'b0);
      check_value("interrupt at 2 words", 32'd0, 32'(interrupt_o));
      repeat (4) send_beat(8'($urandom), 1'b0);
      check_value("interrupt at 3 words", 32'd1, 32'(interrupt_o));
      drain_word(w);
      check_value("interrupt after pop", 32'd0, 32'(interrupt_o));
   endtask

   task automatic system_stream_mode();
      test_name = "system_stream_mode";
      restart_block(1'b1, 1'b1);
      fork
         for (int i = 0; i < 40; i++) begin
            send_beat(8'($urandom), i == 39);
         end
         collect_sys_words(10);
      join
      check_value("tready after tlast", 32'd1, 32'(axis_tready_o));
      read_expect("STATUS", `AXIS_IN_ADDR_STATUS, 32'h5);
      // One more word parks in the FIFO while the sink is stalled
      repeat (4) send_beat(8'($urandom), 1'b0);
      read_expect("LEVEL", `AXIS_IN_ADDR_LEVEL, 32'd1);
      read_expect("DATA in system mode", `AXIS_IN_ADDR_DATA, 32'd0);
      read_expect("LEVEL after DATA read", `AXIS_IN_ADDR_LEVEL, 32'd1);
      read_expect("NWORDS", `AXIS_IN_ADDR_NWORDS, 32'd40);
   endtask

   task automatic disabled_block();
      test_name = "disabled_block";
      restart_block(1'b0, 1'b0);
      hold_refused_beat(8'h3C, 10);
      read_expect("LEVEL", `AXIS_IN_ADDR_LEVEL, 32'd0);
      read_expect("NWORDS", `AXIS_IN_ADDR_NWORDS, 32'd0);
   endtask

   initial begin
      errors        = 0;
      model_acc     = '0;
      model_lane    = 0;
      rst_i         = 1'b1;
      axis_tvalid_i = 1'b0;
      axis_tdata_i  = '0;
      axis_tlast_i  = 1'b0;
      sys_tready_i  = 1'b0;
      csr_valid_i   = 1'b0;
      csr_wen_i     = 1'b0;
      csr_addr_i    = '0;
      csr_wdata_i   = '0;
      void'($urandom(32'hb8501def));
      repeat (5) @(negedge clk);
      rst_i = 1'b0;
      check_after_reset();
      cpu_mode_packing();
      tlast_padding_and_stop();
      full_fifo_backpressure();
      level_interrupt();
      system_stream_mode();
      disabled_block();
      $display("Run complete with %0d error(s)", errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/axis_in_pkg.sv
rtl/axis_in_packer.sv
rtl/axis_in_fifo.sv
rtl/axis_in_csrs.sv
rtl/axis_in_top.sv
dv/axis_in_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -sv
LINTFLAGS ?= --lint-only --timing -sv
TOP       ?= axis_in_tb
RTL_TOP   ?= axis_in_top
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
